//--- common/wb_pkg.sv
package wb_pkg;

    parameter int XLEN         = 32;
    parameter int REG_ADDR_W   = 5;
    parameter int PADDR_TAG_W  = 20;
    parameter int EXCP_CODE_W  = 6;
    parameter int PAGE_OFS_W   = 12;
    parameter int VPN_W        = XLEN - PAGE_OFS_W;
    parameter int COMMIT_CNT_W = 32;

    typedef enum logic [7:0] {
        NOP     = 8'h00,
        ALU_OP  = 8'h01,
        LD_B    = 8'h10,
        LD_BU   = 8'h11,
        LD_H    = 8'h12,
        LD_HU   = 8'h13,
        LD_W    = 8'h14,
        LL      = 8'h15,
        ST_B    = 8'h20,
        ST_H    = 8'h21,
        ST_W    = 8'h22,
        SC      = 8'h23,
        RDCNTVL = 8'h30,
        RDCNTVH = 8'h31,
        RDCNTID = 8'h32
    } alu_op_e;

    // Virtual address, raw or split at the page boundary
    typedef union packed {
        logic [XLEN-1:0] word;
        struct packed {
            logic [VPN_W-1:0]      vpn;
            logic [PAGE_OFS_W-1:0] offset;
        } page;
    } mem_vaddr_u;

endpackage

//--- source/mem_access_classify.sv
`timescale 1ns/1ns

module mem_access_classify
    import wb_pkg::*;
(
    input  alu_op_e op_i,
    input  logic    llbit_i,
    output logic    load_o,
    output logic    store_o,
    output logic    is_cnt_o,
    output logic    sc_attempt_o
);

    logic plain_store;

    always_comb begin
        load_o = op_i inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};
    end

    always_comb begin
        plain_store = op_i inside {ST_B, ST_H, ST_W};
    end

    // A failed SC writes nothing to memory
    always_comb begin
        store_o = plain_store || (sc_attempt_o && llbit_i);
    end

    always_comb begin
        is_cnt_o = op_i inside {RDCNTVL, RDCNTVH, RDCNTID};
    end

    always_comb begin
        sc_attempt_o = (op_i == SC);
    end

endmodule

//--- source/llbit_track.sv
`timescale 1ns/1ns

module llbit_track
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    commit_valid_i,
    input  alu_op_e commit_op_i,
    input  logic    csr_llbit_we_i,
    input  logic    csr_llbit_value_i,
    output logic    llbit_o
);

    logic commit_ll;
    logic commit_sc;

    assign commit_ll = commit_valid_i && (commit_op_i == LL);
    assign commit_sc = commit_valid_i && (commit_op_i == SC);

    // CSR write wins over the committed op
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            llbit_o <= 1'b0;
        end else if (csr_llbit_we_i) begin
            llbit_o <= csr_llbit_value_i;
        end else if (commit_ll) begin
            llbit_o <= 1'b1;
        end else if (commit_sc) begin
            llbit_o <= 1'b0;
        end
    end

    a_ll_sets_bit: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (commit_ll && !csr_llbit_we_i) |=> llbit_o
    ) else $error("committed LL did not set the link bit");

endmodule

//--- writeback/wb_stage.sv
`timescale 1ns/1ns

module wb_stage
    import wb_pkg::*;
#(
    parameter int FTQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          flush_i,

    input  logic                          valid_i,
    input  logic [XLEN-1:0]               pc_i,
    input  logic [31:0]                   instr_i,
    input  alu_op_e                       op_i,
    input  logic                          reg_we_i,
    input  logic [REG_ADDR_W-1:0]         reg_addr_i,
    input  logic [XLEN-1:0]               reg_data_i,
    input  mem_vaddr_u                    load_vaddr_i,
    input  mem_vaddr_u                    store_vaddr_i,
    input  logic [XLEN-1:0]               store_data_i,
    input  logic [PADDR_TAG_W-1:0]        tag_i,
    input  logic                          excp_i,
    input  logic [EXCP_CODE_W-1:0]        excp_code_i,
    input  logic                          need_refetch_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0]  ftq_id_i,
    input  logic                          is_load_i,
    input  logic                          is_store_i,
    input  logic                          is_cnt_i,

    output logic                          wb_valid_o,
    output logic [XLEN-1:0]               wb_pc_o,
    output logic [31:0]                   wb_instr_o,
    output alu_op_e                       wb_op_o,
    output logic                          wb_we_o,
    output logic [REG_ADDR_W-1:0]         wb_addr_o,
    output logic [XLEN-1:0]               wb_data_o,
    output mem_vaddr_u                    wb_load_vaddr_o,
    output mem_vaddr_u                    wb_store_vaddr_o,
    output logic [XLEN-1:0]               wb_store_data_o,
    output logic [PADDR_TAG_W-1:0]        wb_tag_o,
    output logic                          wb_excp_o,
    output logic [EXCP_CODE_W-1:0]        wb_excp_code_o,
    output logic                          wb_refetch_o,
    output logic [$clog2(FTQ_DEPTH)-1:0]  wb_ftq_id_o,
    output logic                          wb_ld_en_o,
    output logic                          wb_st_en_o,
    output logic                          wb_is_cnt_o,

    output logic                          forward_we_o,
    output logic [REG_ADDR_W-1:0]         forward_addr_o,
    output logic [XLEN-1:0]               forward_data_o,
    output logic                          dcache_flush_o,
    output logic [XLEN-1:0]               dcache_flush_pc_o
);

    logic bubble;
    logic take;

    assign bubble = flush_i || stall_i;
    assign take   = valid_i && !bubble;

    // Dispatch sees the write-back triple before it is registered
    assign forward_we_o   = reg_we_i;
    assign forward_addr_o = reg_addr_i;
    assign forward_data_o = reg_data_i;

    assign dcache_flush_o    = excp_i && valid_i;
    assign dcache_flush_pc_o = pc_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o   <= 1'b0;
            wb_we_o      <= 1'b0;
            wb_excp_o    <= 1'b0;
            wb_refetch_o <= 1'b0;
            wb_ld_en_o   <= 1'b0;
            wb_st_en_o   <= 1'b0;
            wb_is_cnt_o  <= 1'b0;
        end else begin
            wb_valid_o   <= take;
            // Excepting instruction never reaches the register file
            wb_we_o      <= take && reg_we_i && !excp_i;
            wb_excp_o    <= take && excp_i;
            wb_refetch_o <= take && need_refetch_i;
            wb_ld_en_o   <= take && is_load_i;
            wb_st_en_o   <= take && is_store_i;
            wb_is_cnt_o  <= take && is_cnt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!bubble) begin
            wb_pc_o          <= pc_i;
            wb_instr_o       <= instr_i;
            wb_op_o          <= op_i;
            wb_addr_o        <= reg_addr_i;
            wb_data_o        <= reg_data_i;
            wb_load_vaddr_o  <= load_vaddr_i;
            wb_store_vaddr_o <= store_vaddr_i;
            wb_store_data_o  <= store_data_i;
            wb_tag_o         <= tag_i;
            wb_excp_code_o   <= excp_code_i;
            wb_ftq_id_o      <= ftq_id_i;
        end
    end

    a_bubble_on_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (flush_i || stall_i) |=> !wb_valid_o
    ) else $error("flush or stall did not leave a bubble in writeback");

endmodule

//--- writeback/commit_trace.sv
`timescale 1ns/1ns

module commit_trace
    import wb_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     wb_valid_i,
    input  logic [XLEN-1:0]          wb_pc_i,
    input  logic [31:0]              wb_instr_i,
    input  alu_op_e                  wb_op_i,
    input  mem_vaddr_u               wb_load_vaddr_i,
    input  mem_vaddr_u               wb_store_vaddr_i,
    input  logic [XLEN-1:0]          wb_store_data_i,
    input  logic [PADDR_TAG_W-1:0]   wb_tag_i,
    input  logic                     wb_excp_i,
    input  logic [EXCP_CODE_W-1:0]   wb_excp_code_i,
    input  logic                     wb_refetch_i,
    input  logic                     wb_ld_en_i,
    input  logic                     wb_st_en_i,
    input  logic                     wb_is_cnt_i,

    output logic                     commit_valid_o,
    output logic [XLEN-1:0]          commit_pc_o,
    output logic [31:0]              commit_instr_o,
    output logic                     commit_ld_en_o,
    output logic                     commit_st_en_o,
    output logic [XLEN-1:0]          commit_ld_paddr_o,
    output logic [XLEN-1:0]          commit_st_paddr_o,
    output logic [XLEN-1:0]          commit_st_data_o,
    output logic                     commit_is_cnt_o,
    output logic                     commit_excp_o,
    output logic [EXCP_CODE_W-1:0]   commit_excp_code_o,
    output logic                     commit_refetch_o,
    output logic [COMMIT_CNT_W-1:0]  commit_count_o
);

    logic retire;

    assign retire = wb_valid_i && !wb_excp_i;

    assign commit_valid_o     = wb_valid_i;
    assign commit_pc_o        = wb_pc_i;
    assign commit_instr_o     = wb_instr_i;
    assign commit_is_cnt_o    = wb_is_cnt_i;
    assign commit_excp_o      = wb_excp_i;
    assign commit_excp_code_o = wb_excp_code_i;
    assign commit_refetch_o   = wb_refetch_i;

    assign commit_ld_en_o = retire && wb_ld_en_i;
    assign commit_st_en_o = retire && wb_st_en_i;

    // Translation tag above the untranslated page offset
    assign commit_ld_paddr_o = {wb_tag_i, wb_load_vaddr_i.page.offset};
    assign commit_st_paddr_o = {wb_tag_i, wb_store_vaddr_i.page.offset};

    // Only the bytes the store actually writes
    always_comb begin
        case (wb_op_i)
            ST_B:    commit_st_data_o = {{(XLEN-8){1'b0}}, wb_store_data_i[7:0]};
            ST_H:    commit_st_data_o = {{(XLEN-16){1'b0}}, wb_store_data_i[15:0]};
            default: commit_st_data_o = wb_store_data_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_count_o <= '0;
        end else if (retire) begin
            commit_count_o <= commit_count_o + 1'b1;
        end
    end

endmodule

//--- source/arch_regfile.sv
`timescale 1ns/1ns

module arch_regfile
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr_i,
    output logic [XLEN-1:0]       rdata_o
);

    logic [XLEN-1:0] regs [0:(1<<REG_ADDR_W)-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads as zero
    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

//--- source/wb_top.sv
`timescale 1ns/1ns

module wb_top
    import wb_pkg::*;
#(
    parameter int FTQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic                          valid_i,
    input  logic [XLEN-1:0]               pc_i,
    input  logic [31:0]                   instr_i,
    input  alu_op_e                       op_i,
    input  logic                          reg_we_i,
    input  logic [REG_ADDR_W-1:0]         reg_addr_i,
    input  logic [XLEN-1:0]               reg_data_i,
    input  mem_vaddr_u                    load_vaddr_i,
    input  mem_vaddr_u                    store_vaddr_i,
    input  logic [XLEN-1:0]               store_data_i,
    input  logic [PADDR_TAG_W-1:0]        tag_i,
    input  logic                          excp_i,
    input  logic [EXCP_CODE_W-1:0]        excp_code_i,
    input  logic                          need_refetch_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0]  ftq_id_i,
    input  logic                          csr_llbit_we_i,
    input  logic                          csr_llbit_value_i,
    input  logic [REG_ADDR_W-1:0]         rf_raddr_i,

    output logic                          forward_we_o,
    output logic [REG_ADDR_W-1:0]         forward_addr_o,
    output logic [XLEN-1:0]               forward_data_o,
    output logic                          dcache_flush_o,
    output logic [XLEN-1:0]               dcache_flush_pc_o,
    output logic                          commit_valid_o,
    output logic [XLEN-1:0]               commit_pc_o,
    output logic [31:0]                   commit_instr_o,
    output logic                          commit_ld_en_o,
    output logic                          commit_st_en_o,
    output logic [XLEN-1:0]               commit_ld_paddr_o,
    output logic [XLEN-1:0]               commit_st_paddr_o,
    output logic [XLEN-1:0]               commit_st_data_o,
    output logic                          commit_is_cnt_o,
    output logic                          commit_excp_o,
    output logic [EXCP_CODE_W-1:0]        commit_excp_code_o,
    output logic                          commit_refetch_o,
    output logic [COMMIT_CNT_W-1:0]       commit_count_o,
    output logic [$clog2(FTQ_DEPTH)-1:0]  wb_ftq_id_o,
    output logic                          llbit_o,
    output logic [XLEN-1:0]               rf_rdata_o
);

    logic                   is_load;
    logic                   is_store;
    logic                   is_cnt;
    logic                   wb_valid;
    logic [XLEN-1:0]        wb_pc;
    logic [31:0]            wb_instr;
    alu_op_e                wb_op;
    logic                   wb_we;
    logic [REG_ADDR_W-1:0]  wb_addr;
    logic [XLEN-1:0]        wb_data;
    mem_vaddr_u             wb_load_vaddr;
    mem_vaddr_u             wb_store_vaddr;
    logic [XLEN-1:0]        wb_store_data;
    logic [PADDR_TAG_W-1:0] wb_tag;
    logic                   wb_excp;
    logic [EXCP_CODE_W-1:0] wb_excp_code;
    logic                   wb_refetch;
    logic                   wb_ld_en;
    logic                   wb_st_en;
    logic                   wb_is_cnt;

    mem_access_classify u_classify (
        .op_i         (op_i),
        .llbit_i      (llbit_o),
        .load_o       (is_load),
        .store_o      (is_store),
        .is_cnt_o     (is_cnt),
        .sc_attempt_o ()
    );

    wb_stage #(
        .FTQ_DEPTH (FTQ_DEPTH)
    ) u_wb_stage (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .valid_i           (valid_i),
        .pc_i              (pc_i),
        .instr_i           (instr_i),
        .op_i              (op_i),
        .reg_we_i          (reg_we_i),
        .reg_addr_i        (reg_addr_i),
        .reg_data_i        (reg_data_i),
        .load_vaddr_i      (load_vaddr_i),
        .store_vaddr_i     (store_vaddr_i),
        .store_data_i      (store_data_i),
        .tag_i             (tag_i),
        .excp_i            (excp_i),
        .excp_code_i       (excp_code_i),
        .need_refetch_i    (need_refetch_i),
        .ftq_id_i          (ftq_id_i),
        .is_load_i         (is_load),
        .is_store_i        (is_store),
        .is_cnt_i          (is_cnt),
        .wb_valid_o        (wb_valid),
        .wb_pc_o           (wb_pc),
        .wb_instr_o        (wb_instr),
        .wb_op_o           (wb_op),
        .wb_we_o           (wb_we),
        .wb_addr_o         (wb_addr),
        .wb_data_o         (wb_data),
        .wb_load_vaddr_o   (wb_load_vaddr),
        .wb_store_vaddr_o  (wb_store_vaddr),
        .wb_store_data_o   (wb_store_data),
        .wb_tag_o          (wb_tag),
        .wb_excp_o         (wb_excp),
        .wb_excp_code_o    (wb_excp_code),
        .wb_refetch_o      (wb_refetch),
        .wb_ftq_id_o       (wb_ftq_id_o),
        .wb_ld_en_o        (wb_ld_en),
        .wb_st_en_o        (wb_st_en),
        .wb_is_cnt_o       (wb_is_cnt),
        .forward_we_o      (forward_we_o),
        .forward_addr_o    (forward_addr_o),
        .forward_data_o    (forward_data_o),
        .dcache_flush_o    (dcache_flush_o),
        .dcache_flush_pc_o (dcache_flush_pc_o)
    );

    commit_trace u_commit_trace (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .wb_valid_i         (wb_valid),
        .wb_pc_i            (wb_pc),
        .wb_instr_i         (wb_instr),
        .wb_op_i            (wb_op),
        .wb_load_vaddr_i    (wb_load_vaddr),
        .wb_store_vaddr_i   (wb_store_vaddr),
        .wb_store_data_i    (wb_store_data),
        .wb_tag_i           (wb_tag),
        .wb_excp_i          (wb_excp),
        .wb_excp_code_i     (wb_excp_code),
        .wb_refetch_i       (wb_refetch),
        .wb_ld_en_i         (wb_ld_en),
        .wb_st_en_i         (wb_st_en),
        .wb_is_cnt_i        (wb_is_cnt),
        .commit_valid_o     (commit_valid_o),
        .commit_pc_o        (commit_pc_o),
        .commit_instr_o     (commit_instr_o),
        .commit_ld_en_o     (commit_ld_en_o),
        .commit_st_en_o     (commit_st_en_o),
        .commit_ld_paddr_o  (commit_ld_paddr_o),
        .commit_st_paddr_o  (commit_st_paddr_o),
        .commit_st_data_o   (commit_st_data_o),
        .commit_is_cnt_o    (commit_is_cnt_o),
        .commit_excp_o      (commit_excp_o),
        .commit_excp_code_o (commit_excp_code_o),
        .commit_refetch_o   (commit_refetch_o),
        .commit_count_o     (commit_count_o)
    );

    llbit_track u_llbit (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .commit_valid_i    (commit_valid_o),
        .commit_op_i       (wb_op),
        .csr_llbit_we_i    (csr_llbit_we_i),
        .csr_llbit_value_i (csr_llbit_value_i),
        .llbit_o           (llbit_o)
    );

    arch_regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wb_we),
        .waddr_i (wb_addr),
        .wdata_i (wb_data),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule

//--- bench/tb_wb_top.sv
`timescale 1ns/1ns

module tb_wb_top
    import wb_pkg::*;
();

    localparam int FTQ_W = $clog2(8);

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    logic                    stall_i;
    logic                    flush_i;
    logic                    valid_i;
    logic [XLEN-1:0]         pc_i;
    logic [31:0]             instr_i;
    alu_op_e                 op_i;
    logic                    reg_we_i;
    logic [REG_ADDR_W-1:0]   reg_addr_i;
    logic [XLEN-1:0]         reg_data_i;
    mem_vaddr_u              load_vaddr_i;
    mem_vaddr_u              store_vaddr_i;
    logic [XLEN-1:0]         store_data_i;
    logic [PADDR_TAG_W-1:0]  tag_i;
    logic                    excp_i;
    logic [EXCP_CODE_W-1:0]  excp_code_i;
    logic                    need_refetch_i;
    logic [FTQ_W-1:0]        ftq_id_i;
    logic                    csr_llbit_we_i;
    logic                    csr_llbit_value_i;
    logic [REG_ADDR_W-1:0]   rf_raddr_i;

    logic                    forward_we_o;
    logic [REG_ADDR_W-1:0]   forward_addr_o;
    logic [XLEN-1:0]         forward_data_o;
    logic                    dcache_flush_o;
    logic [XLEN-1:0]         dcache_flush_pc_o;
    logic                    commit_valid_o;
    logic [XLEN-1:0]         commit_pc_o;
    logic [31:0]             commit_instr_o;
    logic                    commit_ld_en_o;
    logic                    commit_st_en_o;
    logic [XLEN-1:0]         commit_ld_paddr_o;
    logic [XLEN-1:0]         commit_st_paddr_o;
    logic [XLEN-1:0]         commit_st_data_o;
    logic                    commit_is_cnt_o;
    logic                    commit_excp_o;
    logic [EXCP_CODE_W-1:0]  commit_excp_code_o;
    logic                    commit_refetch_o;
    logic [COMMIT_CNT_W-1:0] commit_count_o;
    logic [FTQ_W-1:0]        wb_ftq_id_o;
    logic                    llbit_o;
    logic [XLEN-1:0]         rf_rdata_o;

    int                      checks;
    int                      failures;
    int                      test_base;
    logic [XLEN-1:0]         reg_model [0:31];
    logic [31:0]             exp_count;
    logic [XLEN-1:0]         next_pc;
    logic [XLEN-1:0]         last_pc;
    logic [31:0]             last_instr;
    logic [FTQ_W-1:0]        last_ftq;
    logic                    last_refetch;

    wb_top dut0 (.*);

    always #4 clk = ~clk;

    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            failures++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            failures++;
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_op(input string what, input alu_op_e got, input alu_op_e exp);
        checks++;
        if (got !== exp) begin
            failures++;
            $display("MISMATCH at %0t ns: %s is %s, expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    // Register read takes one cycle to set the read address
    task automatic check_reg(input logic [REG_ADDR_W-1:0] addr, input logic [XLEN-1:0] exp);
        @(posedge clk);
        rf_raddr_i <= addr;
        @(negedge clk);
        checks++;
        if (rf_rdata_o !== exp) begin
            failures++;
            $display("MISMATCH at %0t ns: r%0d reads %h, expected %h",
                     $time, addr, rf_rdata_o, exp);
        end
    endtask

    // Fields that pass straight through to the commit record
    task automatic check_record();
        check_word("commit_pc_o", commit_pc_o, last_pc);
        check_word("commit_instr_o", commit_instr_o, last_instr);
        check_word("wb_ftq_id_o", 32'(wb_ftq_id_o), 32'(last_ftq));
        check_flag("commit_refetch_o", commit_refetch_o, last_refetch);
    endtask

    task automatic drive_instr(input alu_op_e op, input logic we,
                               input logic [REG_ADDR_W-1:0] addr, input logic [XLEN-1:0] data,
                               input logic [XLEN-1:0] vaddr, input logic [PADDR_TAG_W-1:0] tag,
                               input logic excp, input logic [EXCP_CODE_W-1:0] code);
        logic [31:0] r;
        logic [31:0] w;
        r = $urandom();
        w = $urandom();
        @(posedge clk);
        valid_i            <= 1'b1;
        pc_i               <= next_pc;
        instr_i            <= w;
        op_i               <= op;
        reg_we_i           <= we;
        reg_addr_i         <= addr;
        reg_data_i         <= data;
        load_vaddr_i.word  <= vaddr;
        store_vaddr_i.word <= vaddr;
        store_data_i       <= data;
        tag_i              <= tag;
        excp_i             <= excp;
        excp_code_i        <= code;
        need_refetch_i     <= r[FTQ_W];
        ftq_id_i           <= r[FTQ_W-1:0];
        last_pc = next_pc;
        last_instr = w;
        last_ftq = r[FTQ_W-1:0];
        last_refetch = r[FTQ_W];
        next_pc = next_pc + 32'd4;
    endtask

    task automatic release_inputs();
        @(posedge clk);
        valid_i  <= 1'b0;
        reg_we_i <= 1'b0;
        excp_i   <= 1'b0;
        stall_i  <= 1'b0;
        flush_i  <= 1'b0;
    endtask

    task automatic wait_commit();
        int n;
        n = 0;
        @(negedge clk);
        while (!commit_valid_o && n < 8) begin
            n++;
            @(negedge clk);
        end
        if (!commit_valid_o) begin
            failures++;
            $display("Timed out at %0t ns waiting for commit_valid_o to rise", $time);
        end else if (n != 0) begin
            failures++;
            $display("commit_valid_o rose %0d cycles late at %0t ns", n, $time);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (commit_valid_o && n < 40) begin
            n++;
            @(negedge clk);
        end
        if (commit_valid_o) begin
            failures++;
            $display("Timed out at %0t ns waiting for commit_valid_o to fall", $time);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-14s %s (%0d failures)", name,
                 (failures == test_base) ? "passed" : "failed", failures - test_base);
        test_base = failures;
    endtask

    task automatic test_alu_forward();
        drive_instr(ALU_OP, 1'b1, 5'd5, 32'ha5a5_0001, '0, '0, 1'b0, '0);
        @(negedge clk);
        check_flag("forward_we_o", forward_we_o, 1'b1);
        check_word("forward_addr_o", 32'(forward_addr_o), 32'd5);
        check_word("forward_data_o", forward_data_o, 32'ha5a5_0001);
        release_inputs();
        wait_commit();
        check_record();
        reg_model[5] = 32'ha5a5_0001;
        exp_count = exp_count + 32'd1;
        check_reg(5'd5, reg_model[5]);
        // r0 ignores the write
        drive_instr(ALU_OP, 1'b1, 5'd0, 32'h1234_5678, '0, '0, 1'b0, '0);
        release_inputs();
        wait_commit();
        exp_count = exp_count + 32'd1;
        check_reg(5'd0, 32'h0);
        check_word("commit_count_o", commit_count_o, exp_count);
        report_test("alu_forward");
    endtask

    task automatic test_load_store();
        drive_instr(LD_W, 1'b1, 5'd7, 32'h0bad_f00d, 32'h1234_5abc, 20'hfedcb, 1'b0, '0);
        release_inputs();
        wait_commit();
        check_record();
        check_op("committed op", dut0.wb_op, LD_W);
        check_flag("commit_ld_en_o", commit_ld_en_o, 1'b1);
        check_flag("commit_st_en_o", commit_st_en_o, 1'b0);
        check_word("commit_ld_paddr_o", commit_ld_paddr_o, {20'hfedcb, 12'habc});
        reg_model[7] = 32'h0bad_f00d;
        exp_count = exp_count + 32'd1;
        drive_instr(ST_W, 1'b0, 5'd0, 32'hdead_beef, 32'h0000_3ff4, 20'h00abc, 1'b0, '0);
        release_inputs();
        wait_commit();
        check_record();
        check_op("committed op", dut0.wb_op, ST_W);
        check_flag("commit_ld_en_o", commit_ld_en_o, 1'b0);
        check_flag("commit_st_en_o", commit_st_en_o, 1'b1);
        check_word("commit_st_paddr_o", commit_st_paddr_o, {20'h00abc, 12'hff4});
        check_word("commit_st_data_o", commit_st_data_o, 32'hdead_beef);
        exp_count = exp_count + 32'd1;
        check_reg(5'd7, reg_model[7]);
        check_word("commit_count_o", commit_count_o, exp_count);
        report_test("load_store");
    endtask

    task automatic run_sc(input logic exp_store);
        drive_instr(SC, 1'b0, 5'd0, 32'h0000_00c0, 32'h0000_0100, 20'h00001, 1'b0, '0);
        release_inputs();
        wait_commit();
        check_record();
        check_op("committed op", dut0.wb_op, SC);
        check_flag("commit_st_en_o for SC", commit_st_en_o, exp_store);
        exp_count = exp_count + 32'd1;
        @(negedge clk);
        check_flag("llbit_o after SC", llbit_o, 1'b0);
    endtask

    task automatic test_llsc();
        drive_instr(LL, 1'b0, 5'd0, '0, 32'h0000_0100, 20'h00001, 1'b0, '0);
        release_inputs();
        wait_commit();
        check_record();
        check_flag("commit_ld_en_o for LL", commit_ld_en_o, 1'b1);
        exp_count = exp_count + 32'd1;
        @(negedge clk);
        check_flag("llbit_o after LL", llbit_o, 1'b1);
        run_sc(1'b1);
        run_sc(1'b0);
        // CSR override sets the link bit again
        @(posedge clk);
        csr_llbit_we_i    <= 1'b1;
        csr_llbit_value_i <= 1'b1;
        @(posedge clk);
        csr_llbit_we_i    <= 1'b0;
        @(negedge clk);
        check_flag("llbit_o after CSR write", llbit_o, 1'b1);
        run_sc(1'b1);
        check_word("commit_count_o", commit_count_o, exp_count);
        report_test("llsc");
    endtask

    task automatic test_stall_flush();
        for (int i = 0; i < 2; i++) begin
            drive_instr(ALU_OP, 1'b1, 5'd9, 32'h5555_0000 + i, '0, '0, 1'b0, '0);
            if (i == 0) begin
                stall_i <= 1'b1;
            end else begin
                flush_i <= 1'b1;
            end
            release_inputs();
            @(negedge clk);
            check_flag("commit_valid_o after bubble", commit_valid_o, 1'b0);
            check_reg(5'd9, reg_model[9]);
            check_word("commit_count_o", commit_count_o, exp_count);
        end
        report_test("stall_flush");
    endtask

    task automatic test_exception();
        drive_instr(LD_W, 1'b1, 5'd12, 32'h7777_0000, 32'h0000_2010, 20'h0abcd, 1'b1, 6'h0a);
        @(negedge clk);
        check_flag("dcache_flush_o", dcache_flush_o, 1'b1);
        check_word("dcache_flush_pc_o", dcache_flush_pc_o, last_pc);
        release_inputs();
        wait_commit();
        check_record();
        check_flag("commit_excp_o", commit_excp_o, 1'b1);
        check_word("commit_excp_code_o", 32'(commit_excp_code_o), 32'h0a);
        check_flag("commit_ld_en_o", commit_ld_en_o, 1'b0);
        check_flag("commit_st_en_o", commit_st_en_o, 1'b0);
        check_reg(5'd12, reg_model[12]);
        check_word("commit_count_o", commit_count_o, exp_count);
        report_test("exception");
    endtask

    task automatic test_random_alu();
        int unsigned         r;
        alu_op_e             op;
        logic [REG_ADDR_W-1:0] a;
        logic [XLEN-1:0]     d;
        logic                prev_cnt;
        for (int i = 0; i < 20; i++) begin
            r = $urandom() % 4;
            case (r)
                0:       op = ALU_OP;
                1:       op = RDCNTVL;
                2:       op = RDCNTVH;
                default: op = RDCNTID;
            endcase
            a = 5'($urandom());
            d = $urandom();
            drive_instr(op, 1'b1, a, d, '0, '0, 1'b0, '0);
            // Previous instruction is on the commit port now
            if (i > 0) begin
                @(negedge clk);
                check_flag("commit_is_cnt_o", commit_is_cnt_o, prev_cnt);
            end
            prev_cnt = (r != 0);
            if (a != '0) begin
                reg_model[a] = d;
            end
            exp_count = exp_count + 32'd1;
        end
        release_inputs();
        @(negedge clk);
        check_flag("commit_is_cnt_o", commit_is_cnt_o, prev_cnt);
        wait_idle();
        for (int k = 0; k < 32; k++) begin
            check_reg(5'(k), reg_model[k]);
        end
        check_word("commit_count_o", commit_count_o, exp_count);
        report_test("random_alu");
    endtask

    initial begin
        void'($urandom(32'h7a576f78));
        rst_n_i            = 1'b0;
        stall_i            = 1'b0;
        flush_i            = 1'b0;
        valid_i            = 1'b0;
        pc_i               = '0;
        instr_i            = '0;
        op_i               = NOP;
        reg_we_i           = 1'b0;
        reg_addr_i         = '0;
        reg_data_i         = '0;
        load_vaddr_i.word  = '0;
        store_vaddr_i.word = '0;
        store_data_i       = '0;
        tag_i              = '0;
        excp_i             = 1'b0;
        excp_code_i        = '0;
        need_refetch_i     = 1'b0;
        ftq_id_i           = '0;
        csr_llbit_we_i     = 1'b0;
        csr_llbit_value_i  = 1'b0;
        rf_raddr_i         = '0;
        checks             = 0;
        failures           = 0;
        test_base          = 0;
        exp_count          = '0;
        next_pc            = 32'h1c00_0000;
        last_pc            = '0;
        last_instr         = '0;
        last_ftq           = '0;
        last_refetch       = 1'b0;
        for (int k = 0; k < 32; k++) begin
            reg_model[k] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_flag("commit_valid_o after reset", commit_valid_o, 1'b0);
        check_flag("llbit_o after reset", llbit_o, 1'b0);
        check_word("commit_count_o after reset", commit_count_o, '0);
        test_alu_forward();
        test_load_store();
        test_llsc();
        test_stall_flush();
        test_exception();
        test_random_alu();
        $display("checks=%0d failures=%0d", checks, failures);
        if (failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- build.f
common/wb_pkg.sv
source/mem_access_classify.sv
source/llbit_track.sv
writeback/wb_stage.sv
writeback/commit_trace.sv
source/arch_regfile.sv
source/wb_top.sv
bench/tb_wb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_top \
    -f build.f -o tb_wb_top \
    && ./obj_dir/tb_wb_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log \
    && { echo "simulation reported failures"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
